/* cpu16.f */
+incdir+tb
logic/cpu16_pkg.sv
logic/cpu16_alu.sv
logic/cpu16_regfile.sv
logic/cpu16_controller.sv
logic/cpu16_datapath.sv
logic/cpu16_memory.sv
logic/cpu16_top.sv
tb/cpu16_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cpu16_tb
FILELIST ?= cpu16.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/cpu16_tb_programs.svh */
`ifndef CPU16_TB_PROGRAMS_SVH
`define CPU16_TB_PROGRAMS_SVH

//////////////////////////////
// Test programs in one flat ROM
localparam int rom_words = 156;
localparam int store_words = 33;
localparam int num_entries = 6;

localparam word_t prog_rom [rom_words] = '{
	// Register ALU ops on movi/lui values with stores at 0x40
	16'hD1F0, 16'hF2A5, 16'hD333, 16'h0223, 16'h04D2, 16'h0411, 16'h05D2, 16'h0521,
	16'h06D2, 16'h0631, 16'h07D2, 16'h0751, 16'h08D1, 16'h0892, 16'hD940, 16'h4249,
	16'h5901, 16'h4449, 16'h5901, 16'h4549, 16'h5901, 16'h4649, 16'h5901, 16'h4749,
	16'h5901, 16'h4849, 16'hCE00,
	// Immediate forms and their extension with stores at 0x50
	16'hD110, 16'h51FE, 16'hD210, 16'h92FD, 16'hD300, 16'h53FF, 16'h1380, 16'hF412,
	16'h2480, 16'hF5FF, 16'h35F0, 16'hD69C, 16'hF781, 16'h68FF, 16'hD950, 16'h4149,
	16'h5901, 16'h4249, 16'h5901, 16'h4349, 16'h5901, 16'h4449, 16'h5901, 16'h4549,
	16'h5901, 16'h4649, 16'h5901, 16'h4749, 16'h5901, 16'h4849, 16'hCE00,
	// Shifts with stores at 0x60
	16'hD1C3, 16'h8104, 16'hF2C3, 16'h8213, 16'hD30E, 16'hF4F0, 16'h8443, 16'hD501,
	16'hD603, 16'h8546, 16'hD960, 16'h4149, 16'h5901, 16'h4249, 16'h5901, 16'h4449,
	16'h5901, 16'h4549, 16'hCE00,
	// Store, load back and store again
	16'hF1BE, 16'h21EF, 16'hD970, 16'h4149, 16'h4209, 16'hD871, 16'h4248, 16'h5201,
	16'h4248, 16'hCE00,
	// Flags, branches, counted loop, jal and jcond
	16'hD105, 16'h52FF, 16'hD64E, 16'hD754, 16'hD980, 16'h01B2,
	16'hC003, 16'h4649, 16'hCE02, 16'h4749, 16'h5901,
	16'hC103, 16'h4649, 16'hCE02, 16'h4749, 16'h5901,
	16'hC403, 16'h4649, 16'hCE02, 16'h4749, 16'h5901,
	16'hC503, 16'h4649, 16'hCE02, 16'h4749, 16'h5901,
	16'hC603, 16'h4649, 16'hCE02, 16'h4749, 16'h5901,
	16'hC703, 16'h4649, 16'hCE02, 16'h4749, 16'h5901,
	16'hB105,
	16'hC003, 16'h4649, 16'hCE02, 16'h4749, 16'h5901,
	16'hCE03, 16'h4649, 16'hCE02, 16'h4749, 16'h5901,
	16'h02B1,
	16'hC603, 16'h4649, 16'hCE02, 16'h4749, 16'h5901,
	16'hD300, 16'hD405, 16'h5301, 16'h03B4, 16'hC1FE, 16'h4349, 16'h5901,
	16'hCE05, 16'hDC5B, 16'h4C49, 16'h5901, 16'h4ECB, 16'hDA3D, 16'h4B8A, 16'h4B49,
	16'hCE00
};

// Expected stores as {addr, data}
localparam store_t store_exp [store_words] = '{
	24'h40A533, 24'h410030, 24'h42A5F3, 24'h43A5C3, 24'h44A623, 24'h455BBD,
	24'h50000E, 24'h510013, 24'h520080, 24'h531280, 24'h54FFF0, 24'h55009C,
	24'h568100, 24'h57FFFF,
	24'h600C30, 24'h611860, 24'h623C00, 24'h630008,
	24'h70BEEF, 24'h71BEEF, 24'h71BEF0,
	// Marker 0x4E means not taken and 0x54 means taken
	24'h80004E, 24'h810054, 24'h820054, 24'h83004E, 24'h84004E, 24'h850054,
	24'h860054, 24'h870054, 24'h880054, 24'h890005, 24'h8A005B, 24'h8B0043
};

// Last entry reruns the first program
localparam int entry_start [num_entries] = '{0, 27, 58, 77, 87, 0};
localparam int entry_len [num_entries] = '{27, 31, 19, 10, 69, 27};
localparam int entry_store_start [num_entries] = '{0, 6, 14, 18, 21, 0};
localparam int entry_store_cnt [num_entries] = '{6, 8, 4, 3, 12, 6};

`endif

/* tb/cpu16_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu16_tb;
	import cpu16_pkg::*;

	`include "cpu16_tb_programs.svh"

	localparam int clk_period = 100;
	localparam int reset_cycles = 5;
	localparam int max_gap = 2;
	localparam int quiet_cycles = 8;

	logic clk = 1'b0;
	logic rst;
	logic prog_valid;
	mem_addr_t prog_addr;
	word_t prog_data;
	logic store_valid;
	store_t store;

	int store_errors = 0;
	int idle_errors = 0;

	cpu16_top cpu16_top_inst (
		.clk(clk),
		.rst(rst),
		.prog_valid(prog_valid),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.store_valid(store_valid),
		.store(store)
	);

	always #(clk_period / 2) clk = ~clk;

	//////////////////////////////
	// Compare tasks
	task automatic check_store(input store_t got, input store_t exp);
		if (got !== exp) begin
			store_errors++;
			$display("MISMATCH store.addr got %h exp %h, store.data got %h exp %h",
				got.addr, exp.addr, got.data, exp.data);
		end
	endtask

	task automatic check_idle(input string phase);
		if (store_valid === 1'b1) begin
			idle_errors++;
			$display("Unexpected store during %s at address %h", phase, store.addr);
		end
	endtask

	// Reset plus loading time per entry, execution bounded by 12 cycles a word
	function automatic int watchdog_cycles();
		int total;
		total = 0;
		for (int e = 0; e < num_entries; e++)
			total += entry_len[e] * 3 * 4 + entry_len[e] * (max_gap + 1) +
				reset_cycles + quiet_cycles + 4;
		return total;
	endfunction

	//////////////////////////////
	// Loader with random idle gaps
	task automatic load_program(input int e);
		int gap;
		int cycles;
		cycles = 0;
		@(negedge clk);
		rst = 1'b1;
		prog_valid = 1'b0;
		for (int i = 0; i < entry_len[e]; i++) begin
			gap = int'($urandom % (max_gap + 1));
			repeat (gap) begin
				@(negedge clk);
				check_idle("loading");
				prog_valid = 1'b0;
				cycles++;
			end
			@(negedge clk);
			check_idle("loading");
			prog_valid = 1'b1;
			prog_addr = mem_addr_t'(i);
			prog_data = prog_rom[entry_start[e] + i];
			cycles++;
		end
		@(negedge clk);
		check_idle("loading");
		prog_valid = 1'b0;
		cycles++;
		while (cycles < reset_cycles) begin
			@(negedge clk);
			check_idle("reset");
			cycles++;
		end
		@(negedge clk);
		check_idle("reset");
		rst = 1'b0;
	endtask

	task automatic collect_stores(input int e);
		int n;
		n = 0;
		while (n < entry_store_cnt[e]) begin
			@(negedge clk);
			if (store_valid === 1'b1) begin
				check_store(store, store_exp[entry_store_start[e] + n]);
				n++;
			end
		end
		// Program sits in its final branch, nothing more may be stored
		repeat (quiet_cycles) begin
			@(negedge clk);
			check_idle("halt loop");
		end
	endtask

	initial begin
		int limit;
		limit = watchdog_cycles();
		#(limit * clk_period);
		$display("Watchdog expired after %0d cycles, expected stores never arrived", limit);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		rst = 1'b1;
		prog_valid = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		void'($urandom(32'h7a25));
		for (int e = 0; e < num_entries; e++) begin
			load_program(e);
			collect_stores(e);
		end
		$display("Summary: %0d store mismatches, %0d unexpected stores",
			store_errors, idle_errors);
		if (store_errors == 0 && idle_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/cpu16_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu16_top (
	input wire clk,
	input wire rst,
	input wire prog_valid,
	input wire cpu16_pkg::mem_addr_t prog_addr,
	input wire cpu16_pkg::word_t prog_data,
	output logic store_valid,
	output cpu16_pkg::store_t store
);
	import cpu16_pkg::*;

	inst_fields_t fields;
	ctrl_t ctrl;
	word_t instruction;
	word_t mem_rdata;
	word_t mem_wdata;
	mem_addr_t mem_addr;
	logic mem_write;

	cpu16_controller controller_inst (
		.clk(clk),
		.rst(rst),
		.instruction(instruction),
		.fields(fields),
		.ctrl(ctrl)
	);

	cpu16_datapath datapath_inst (
		.clk(clk),
		.rst(rst),
		.fields(fields),
		.ctrl(ctrl),
		.mem_rdata(mem_rdata),
		.instruction(instruction),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_write(mem_write)
	);

	cpu16_memory memory_inst (
		.clk(clk),
		.rst(rst),
		.load_valid(prog_valid),
		.load_addr(prog_addr),
		.load_data(prog_data),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.write(mem_write),
		.rdata(mem_rdata)
	);

	// Every CPU store is visible outside
	assign store_valid = mem_write;
	assign store.addr = mem_addr;
	assign store.data = mem_wdata;

endmodule

`default_nettype wire

/* logic/cpu16_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu16_memory (
	input wire clk,
	input wire rst,
	input wire load_valid,
	input wire cpu16_pkg::mem_addr_t load_addr,
	input wire cpu16_pkg::word_t load_data,
	input wire cpu16_pkg::mem_addr_t addr,
	input wire cpu16_pkg::word_t wdata,
	input wire write,
	output cpu16_pkg::word_t rdata
);
	import cpu16_pkg::*;

	word_t mem [mem_words];

	// Loader owns the write port during reset, the CPU afterwards
	always_ff @(posedge clk) begin
		if (rst && load_valid)
			mem[load_addr] <= load_data;
		else if (!rst && write)
			mem[addr] <= wdata;
	end

	// Registered read, old data on a same-cycle write
	always_ff @(posedge clk) begin
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

/* logic/cpu16_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu16_datapath (
	input wire clk,
	input wire rst,
	input wire cpu16_pkg::inst_fields_t fields,
	input wire cpu16_pkg::ctrl_t ctrl,
	input wire cpu16_pkg::word_t mem_rdata,
	output cpu16_pkg::word_t instruction,
	output cpu16_pkg::mem_addr_t mem_addr,
	output cpu16_pkg::word_t mem_wdata,
	output logic mem_write
);
	import cpu16_pkg::*;

	word_t pc, pc_plus_one, ir;
	word_t rd_dst, rd_src;
	word_t alu_a, alu_b, alu_result;
	word_t imm_ext, shift_amt, wb_data;
	word_t fetch_addr, addr_full;
	flags_t flags_q, alu_flags;
	logic fetch_q, cond_taken;

	cpu16_regfile regfile_inst (
		.clk(clk),
		.rst(rst),
		.rd_addr_a(fields.dst),
		.rd_addr_b(fields.src),
		.rd_data_a(rd_dst),
		.rd_data_b(rd_src),
		.wr_en(ctrl.reg_write),
		.wr_addr(fields.dst),
		.wr_data(wb_data)
	);

	cpu16_alu alu_inst (
		.a(alu_a),
		.b(alu_b),
		.op(ctrl.alu_op),
		.result(alu_result),
		.flags(alu_flags)
	);

	//////////////////////////////
	// Operand selection
	assign imm_ext = ctrl.sign_ext_imm ? {{8{fields.immediate[7]}}, fields.immediate} :
		{8'h00, fields.immediate};

	// lsh takes a signed nibble as direction plus magnitude
	assign shift_amt = {11'd0, rd_src[3], rd_src[3] ? 4'd0 - rd_src[3:0] : rd_src[3:0]};

	assign alu_a = ctrl.alu_src_a ? rd_dst : pc;

	always_comb begin
		if (ctrl.alu_src_b)
			alu_b = imm_ext;
		else if (ctrl.alu_op == alu_shift)
			alu_b = shift_amt;
		else
			alu_b = rd_src;
	end

	//////////////////////////////
	// Flags and branch condition
	always_ff @(posedge clk) begin
		if (rst)
			flags_q <= '0;
		else if (ctrl.flags_write)
			flags_q <= alu_flags;
	end

	always_comb begin
		case (fields.cond)
			cc_eq: cond_taken = flags_q.z;
			cc_ne: cond_taken = !flags_q.z;
			cc_lo: cond_taken = flags_q.l;
			cc_hs: cond_taken = !flags_q.l;
			cc_lt: cond_taken = flags_q.n;
			cc_ge: cond_taken = !flags_q.n;
			cc_uc: cond_taken = 1'b1;
			default: cond_taken = 1'b0;
		endcase
	end

	//////////////////////////////
	// PC, fetch and memory address
	assign pc_plus_one = pc + 16'd1;
	assign fetch_addr = (ctrl.pc_src && cond_taken) ? alu_result : pc_plus_one;

	always_comb begin
		case (ctrl.pc_addr_src)
			2'b00: addr_full = pc_plus_one;
			2'b01: addr_full = fetch_addr;
			default: addr_full = rd_src;
		endcase
	end

	assign mem_addr = addr_full[7:0];

	// All ones so that the boot fetch lands on address 0
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= 16'hffff;
			fetch_q <= 1'b0;
		end else begin
			fetch_q <= ctrl.pc_write;
			if (ctrl.pc_write)
				pc <= fetch_addr;
		end
	end

	// Fetched word arrives one cycle after its address
	always_ff @(posedge clk) begin
		if (fetch_q)
			ir <= mem_rdata;
	end

	assign instruction = ir;

	// Write-back source
	always_comb begin
		case (ctrl.reg_src)
			2'b01: wb_data = pc_plus_one;
			2'b10: wb_data = mem_rdata;
			default: wb_data = alu_result;
		endcase
	end

	assign mem_wdata = rd_dst;
	assign mem_write = ctrl.mem_write;

endmodule

`default_nettype wire

/* logic/cpu16_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu16_controller (
	input wire clk,
	input wire rst,
	input wire cpu16_pkg::word_t instruction,
	output cpu16_pkg::inst_fields_t fields,
	output cpu16_pkg::ctrl_t ctrl
);
	import cpu16_pkg::*;

	ctrl_state_t state, next_state;
	nibble_t oper, func;
	alu_op_t alu_op;
	logic src_a, src_b, sign_ext;
	logic writes_reg, sets_flags;
	logic is_load, is_stor, is_jump;
	logic [1:0] reg_src;

	// Register functions and immediate opcodes share one encoding
	function automatic alu_op_t code_to_alu(nibble_t code);
		case (code)
			fn_and: return alu_and;
			fn_or: return alu_or;
			fn_xor: return alu_xor;
			fn_add, fn_addu: return alu_add;
			fn_sub, fn_cmp: return alu_sub;
			default: return alu_pass_b;
		endcase
	endfunction

	function automatic logic known_code(nibble_t code);
		return code inside {fn_and, fn_or, fn_xor, fn_add, fn_addu, fn_sub, fn_cmp, fn_mov};
	endfunction

	//////////////////////////////
	// Field split
	assign oper = instruction[15:12];
	assign func = instruction[7:4];
	assign fields.oper = oper;
	assign fields.func = func;
	assign fields.immediate = instruction[7:0];
	assign fields.dst = instruction[11:8];
	assign fields.src = instruction[3:0];
	// Conditional transfers keep the condition where dst would sit
	// jal runs unconditional
	assign fields.cond = (oper == op_bcond || (oper == op_special && func == fn_jcond)) ?
		instruction[11:8] : cc_uc;

	//////////////////////////////
	// Instruction decode
	always_comb begin
		alu_op = alu_pass_b;
		src_a = 1'b1;
		src_b = 1'b0;
		sign_ext = 1'b0;
		writes_reg = 1'b0;
		sets_flags = 1'b0;
		reg_src = 2'b00;
		is_load = 1'b0;
		is_stor = 1'b0;
		is_jump = 1'b0;
		case (oper)
			op_register: begin
				alu_op = code_to_alu(func);
				writes_reg = known_code(func) && func != fn_cmp;
				sets_flags = func == fn_cmp;
			end
			op_andi, op_ori, op_xori, op_addi, op_addui, op_subi, op_cmpi, op_movi: begin
				alu_op = code_to_alu(oper);
				src_b = 1'b1;
				sign_ext = oper inside {op_addi, op_addui, op_subi, op_cmpi};
				writes_reg = oper != op_cmpi;
				sets_flags = oper == op_cmpi;
			end
			op_lui: begin
				alu_op = alu_lui;
				src_b = 1'b1;
				writes_reg = 1'b1;
			end
			op_shift: begin
				alu_op = alu_shift;
				src_b = func != fn_lsh;
				writes_reg = func inside {fn_lshil, fn_lshir, fn_lsh};
			end
			op_bcond: begin
				// Target is PC plus the signed displacement
				alu_op = alu_add;
				src_a = 1'b0;
				src_b = 1'b1;
				sign_ext = 1'b1;
				is_jump = 1'b1;
			end
			op_special: begin
				is_load = func == fn_load;
				is_stor = func == fn_stor;
				is_jump = func inside {fn_jal, fn_jcond};
				writes_reg = func == fn_jal;
				reg_src = (func == fn_load) ? 2'b10 : (func == fn_jal) ? 2'b01 : 2'b00;
			end
			default: ;
		endcase
	end

	//////////////////////////////
	// State machine
	always_ff @(posedge clk) begin
		if (rst)
			state <= st_boot;
		else
			state <= next_state;
	end

	// Loads and stores hold the single memory port for a third cycle
	always_comb begin
		case (state)
			st_boot: next_state = st_decode;
			st_decode: next_state = st_calculate;
			st_calculate: next_state = (is_load || is_stor) ? st_load : st_decode;
			default: next_state = st_decode;
		endcase
	end

	assign ctrl.alu_op = alu_op;
	assign ctrl.alu_src_a = src_a;
	assign ctrl.alu_src_b = src_b;
	assign ctrl.sign_ext_imm = sign_ext;
	assign ctrl.reg_src = reg_src;
	// Boot sees a stale instruction word, so no jump target there
	assign ctrl.pc_src = state != st_boot && is_jump;
	assign ctrl.mem_write = is_stor && state == st_calculate;
	assign ctrl.flags_write = sets_flags && state == st_calculate;
	assign ctrl.reg_write = (state == st_calculate && writes_reg) ||
		(state == st_load && is_load);
	assign ctrl.pc_write = next_state == st_decode;
	assign ctrl.pc_addr_src = {!ctrl.pc_write, ctrl.pc_src};

endmodule

`default_nettype wire

/* logic/cpu16_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu16_regfile (
	input wire clk,
	input wire rst,
	input wire cpu16_pkg::reg_addr_t rd_addr_a,
	input wire cpu16_pkg::reg_addr_t rd_addr_b,
	output cpu16_pkg::word_t rd_data_a,
	output cpu16_pkg::word_t rd_data_b,
	input wire wr_en,
	input wire cpu16_pkg::reg_addr_t wr_addr,
	input wire cpu16_pkg::word_t wr_data
);
	import cpu16_pkg::*;

	word_t regs [16];

	// Cleared registers give repeatable runs after every reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

/* logic/cpu16_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu16_alu (
	input wire cpu16_pkg::word_t a,
	input wire cpu16_pkg::word_t b,
	input wire cpu16_pkg::alu_op_t op,
	output cpu16_pkg::word_t result,
	output cpu16_pkg::flags_t flags
);
	import cpu16_pkg::*;

	logic shift_right;
	logic [3:0] shift_count;

	// Shift operand carries direction in bit 4, count in the low nibble
	assign shift_right = b[4];
	assign shift_count = b[3:0];

	always_comb begin
		case (op)
			alu_and: result = a & b;
			alu_or: result = a | b;
			alu_xor: result = a ^ b;
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_shift: result = shift_right ? (a >> shift_count) : (a << shift_count);
			alu_lui: result = {b[7:0], 8'h00};
			default: result = b;
		endcase
	end

	//////////////////////////////
	// Compare flags, a against b
	assign flags.z = a == b;
	assign flags.l = a < b;
	assign flags.n = $signed(a) < $signed(b);

endmodule

`default_nettype wire

/* logic/cpu16_pkg.sv */
`default_nettype none

package cpu16_pkg;

	typedef logic [15:0] word_t;
	typedef logic [3:0] reg_addr_t;
	typedef logic [7:0] mem_addr_t;
	typedef logic [3:0] nibble_t;

	localparam int mem_words = 256;

	//////////////////////////////
	// Opcodes, top nibble
	localparam nibble_t op_register = 4'b0000;
	localparam nibble_t op_andi = 4'b0001;
	localparam nibble_t op_ori = 4'b0010;
	localparam nibble_t op_xori = 4'b0011;
	localparam nibble_t op_special = 4'b0100;
	localparam nibble_t op_addi = 4'b0101;
	localparam nibble_t op_addui = 4'b0110;
	localparam nibble_t op_shift = 4'b1000;
	localparam nibble_t op_subi = 4'b1001;
	localparam nibble_t op_cmpi = 4'b1011;
	localparam nibble_t op_bcond = 4'b1100;
	localparam nibble_t op_movi = 4'b1101;
	localparam nibble_t op_lui = 4'b1111;

	// Register functions, same codes as the matching immediate opcodes
	localparam nibble_t fn_and = 4'b0001;
	localparam nibble_t fn_or = 4'b0010;
	localparam nibble_t fn_xor = 4'b0011;
	localparam nibble_t fn_add = 4'b0101;
	localparam nibble_t fn_addu = 4'b0110;
	localparam nibble_t fn_sub = 4'b1001;
	localparam nibble_t fn_cmp = 4'b1011;
	localparam nibble_t fn_mov = 4'b1101;

	// Shift functions
	localparam nibble_t fn_lshil = 4'b0000;
	localparam nibble_t fn_lshir = 4'b0001;
	localparam nibble_t fn_lsh = 4'b0100;

	// Special functions
	localparam nibble_t fn_load = 4'b0000;
	localparam nibble_t fn_stor = 4'b0100;
	localparam nibble_t fn_jal = 4'b1000;
	localparam nibble_t fn_jcond = 4'b1100;

	//////////////////////////////
	// Branch conditions
	localparam nibble_t cc_eq = 4'b0000;
	localparam nibble_t cc_ne = 4'b0001;
	localparam nibble_t cc_lo = 4'b0100;
	localparam nibble_t cc_hs = 4'b0101;
	localparam nibble_t cc_lt = 4'b0110;
	localparam nibble_t cc_ge = 4'b0111;
	localparam nibble_t cc_uc = 4'b1110;

	typedef enum logic [2:0] {
		alu_and,
		alu_or,
		alu_xor,
		alu_add,
		alu_sub,
		alu_pass_b,
		alu_shift,
		alu_lui
	} alu_op_t;

	typedef enum logic [1:0] {
		st_boot,
		st_decode,
		st_calculate,
		st_load
	} ctrl_state_t;

	typedef struct packed {
		nibble_t oper;
		nibble_t func;
		nibble_t cond;
		logic [7:0] immediate;
		reg_addr_t dst;
		reg_addr_t src;
	} inst_fields_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic alu_src_a;
		logic alu_src_b;
		logic sign_ext_imm;
		logic mem_write;
		logic reg_write;
		logic [1:0] reg_src;
		logic pc_write;
		logic pc_src;
		logic [1:0] pc_addr_src;
		logic flags_write;
	} ctrl_t;

	typedef struct packed {
		logic z;
		logic l;
		logic n;
	} flags_t;

	typedef struct packed {
		mem_addr_t addr;
		word_t data;
	} store_t;

endpackage

`default_nettype wire
